/* logic/pool_settings.svh */
`ifndef POOL_SETTINGS_SVH
`define POOL_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Channel and word sizes
//////////////////////////////////////////////////////////////////////

// Channels per feature-map point
`define ST2_POOL_CI   3

// Signed partial sum width, one channel
`define ST2_POOL_IBW  19

// Activation width after requantization
`define ST2_POOL_OBW  8

//////////////////////////////////////////////////////////////////////
// Frame geometry and requantization
//////////////////////////////////////////////////////////////////////

// Frame size in points, both even
`define FMAP_W        8
`define FMAP_H        8

// Arithmetic right shift before saturation
`define REQ_SHIFT     4

`endif

/* logic/pool_pkg.sv */
`include "pool_settings.svh"

package pool_pkg;

    // Counter widths derived from frame size
    localparam int COL_W  = (`FMAP_W > 2) ? $clog2(`FMAP_W) : 1;
    localparam int ROW_W  = (`FMAP_H > 2) ? $clog2(`FMAP_H) : 1;
    // Line buffer address, one entry per column pair
    localparam int PCOL_W = (`FMAP_W > 4) ? $clog2(`FMAP_W / 2) : 1;

    // One channel partial sum, signed
    typedef logic signed [`ST2_POOL_IBW-1:0] fmap_word_t;

    // One channel activation, unsigned
    typedef logic [`ST2_POOL_OBW-1:0] act_t;

    // Column position inside the frame
    typedef logic [COL_W-1:0] col_idx_t;

    // Row position inside the frame
    typedef logic [ROW_W-1:0] row_idx_t;

    // Pooled column, line buffer index
    typedef logic [PCOL_W-1:0] pool_col_t;

endpackage

/* logic/pool_stream_if.sv */
`include "pool_settings.svh"

// Tagged input point, tracker to pooling core
interface pool_stream_if;

    // Single-cycle point strobe
    logic valid;

    // All channel words of one point, channel 0 in the LSBs
    logic [`ST2_POOL_CI*`ST2_POOL_IBW-1:0] fmap;

    // Position parity tags
    logic col_odd;
    logic row_odd;

    // Bottom-right point of the frame
    logic frame_last;

    // Tracker side
    modport src (
        output valid,
        output fmap,
        output col_odd,
        output row_odd,
        output frame_last
    );

    // Pooling core side
    modport dst (
        input valid,
        input fmap,
        input col_odd,
        input row_odd,
        input frame_last
    );

endinterface

/* logic/fmap_position_tracker.sv */
`include "pool_settings.svh"

module fmap_position_tracker (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  i_valid,
    input  logic [`ST2_POOL_CI*`ST2_POOL_IBW-1:0] i_fmap,
    pool_stream_if.src                            o_pt
);

    import pool_pkg::*;

    // Position of the next incoming point
    col_idx_t col_q;
    row_idx_t row_q;

    logic col_end;
    logic row_end;

    assign col_end = (col_q == col_idx_t'(`FMAP_W - 1));
    assign row_end = (row_q == row_idx_t'(`FMAP_H - 1));

    //////////////////////////////////////////////////////////////////////
    // Raster counters
    //////////////////////////////////////////////////////////////////////

    // Wrap at frame edge, next frame starts at 0,0 with no gap
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (i_valid) begin
            if (col_end) begin
                col_q <= '0;
                // Row steps only at end of line
                row_q <= row_end ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tagged point register
    //////////////////////////////////////////////////////////////////////

    // Strobe and end-of-frame flag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_pt.valid      <= 1'b0;
            o_pt.frame_last <= 1'b0;
        end else begin
            o_pt.valid      <= i_valid;
            o_pt.frame_last <= i_valid && col_end && row_end;
        end
    end

    // Point data and parity, only meaningful with valid
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_pt.fmap    <= i_fmap;
            o_pt.col_odd <= col_q[0];
            o_pt.row_odd <= row_q[0];
        end
    end

endmodule

/* logic/max_pool_2x2.sv */
`include "pool_settings.svh"

module max_pool_2x2 (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_valid,
    input  logic                i_col_odd,
    input  logic                i_row_odd,
    input  pool_pkg::fmap_word_t i_fmap,
    output logic                o_valid,
    output pool_pkg::fmap_word_t o_fmap
);

    import pool_pkg::*;

    // Even column value waiting for its partner
    fmap_word_t even_q;

    // Horizontal pair maxima of the last even row
    fmap_word_t line_buf [`FMAP_W/2];

    // Column pair index inside the current row
    pool_col_t pcol_q;

    fmap_word_t pair_max;
    fmap_word_t upper_max;
    fmap_word_t win_max;

    logic pair_done;

    //////////////////////////////////////////////////////////////////////
    // Horizontal and vertical compare
    //////////////////////////////////////////////////////////////////////

    // Signed compare on both stages
    assign pair_max  = (i_fmap > even_q) ? i_fmap : even_q;
    assign upper_max = line_buf[pcol_q];
    assign win_max   = (pair_max > upper_max) ? pair_max : upper_max;

    // Odd column closes a horizontal pair
    assign pair_done = i_valid && i_col_odd;

    // Hold left point of the pair
    always_ff @(posedge clk) begin
        if (i_valid && !i_col_odd) begin
            even_q <= i_fmap;
        end
    end

    // Pair counter, wraps once per row
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pcol_q <= '0;
        end else if (pair_done) begin
            if (pcol_q == pool_col_t'(`FMAP_W/2 - 1)) begin
                pcol_q <= '0;
            end else begin
                pcol_q <= pcol_q + 1'b1;
            end
        end
    end

    // Even row stores pair maximum for the row below
    always_ff @(posedge clk) begin
        if (pair_done && !i_row_odd) begin
            line_buf[pcol_q] <= pair_max;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Window output
    //////////////////////////////////////////////////////////////////////

    // Bottom-right point of a window
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= pair_done && i_row_odd;
        end
    end

    always_ff @(posedge clk) begin
        if (pair_done && i_row_odd) begin
            o_fmap <= win_max;
        end
    end

endmodule

/* logic/stage2_pooling_core.sv */
`include "pool_settings.svh"

module stage2_pooling_core (
    input  logic                                  clk,
    input  logic                                  reset_n,
    pool_stream_if.dst                            i_pt,
    output logic                                  o_valid,
    output logic [`ST2_POOL_CI*`ST2_POOL_IBW-1:0] o_fmap,
    output logic                                  o_last
);

    import pool_pkg::*;

    // Per-unit strobes and results
    logic [`ST2_POOL_CI-1:0]            unit_valid;
    fmap_word_t [`ST2_POOL_CI-1:0]      unit_out;

    // Frame end, aligned with unit output
    logic last_d;

    logic all_valid;

    assign all_valid = &unit_valid;

    //////////////////////////////////////////////////////////////////////
    // One pooling unit per channel
    //////////////////////////////////////////////////////////////////////

    for (genvar ci = 0; ci < `ST2_POOL_CI; ci++) begin : g_ch
        fmap_word_t ch_in;

        // Channel slice of the packed point
        assign ch_in = i_pt.fmap[ci*`ST2_POOL_IBW +: `ST2_POOL_IBW];

        max_pool_2x2 u_pool (
            .clk       (clk),
            .reset_n   (reset_n),
            .i_valid   (i_pt.valid),
            .i_col_odd (i_pt.col_odd),
            .i_row_odd (i_pt.row_odd),
            .i_fmap    (ch_in),
            .o_valid   (unit_valid[ci]),
            .o_fmap    (unit_out[ci])
        );
    end

    // Same one-cycle delay as the units
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_d <= 1'b0;
        end else begin
            last_d <= i_pt.valid && i_pt.frame_last;
        end
    end

    // Joined output stage, all channels together
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            o_valid <= all_valid;
            o_last  <= all_valid && last_d;
        end
    end

    always_ff @(posedge clk) begin
        if (all_valid) begin
            o_fmap <= unit_out;
        end
    end

endmodule

/* logic/pool_requantizer.sv */
`include "pool_settings.svh"

module pool_requantizer (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  i_valid,
    input  logic [`ST2_POOL_CI*`ST2_POOL_IBW-1:0] i_fmap,
    input  logic                                  i_last,
    output logic                                  o_valid,
    output pool_pkg::act_t [`ST2_POOL_CI-1:0]     o_act,
    output logic                                  o_last
);

    import pool_pkg::*;

    // Largest activation, as a feature word
    localparam fmap_word_t ACT_MAX = fmap_word_t'((1 << `ST2_POOL_OBW) - 1);

    act_t [`ST2_POOL_CI-1:0] act_next;

    // ReLU, scale, clamp
    function automatic act_t requant(input fmap_word_t w);
        fmap_word_t scaled;
        scaled = w >>> `REQ_SHIFT;
        if (w < 0) begin
            return '0;
        end else if (scaled > ACT_MAX) begin
            return '1;
        end
        return act_t'(scaled);
    endfunction

    always_comb begin
        for (int ci = 0; ci < `ST2_POOL_CI; ci++) begin
            act_next[ci] = requant(i_fmap[ci*`ST2_POOL_IBW +: `ST2_POOL_IBW]);
        end
    end

    // Output register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            o_valid <= i_valid;
            o_last  <= i_valid && i_last;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_act <= act_next;
        end
    end

endmodule

/* logic/stage2_pool_top.sv */
`include "pool_settings.svh"

module stage2_pool_top (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  i_valid,
    input  logic [`ST2_POOL_CI*`ST2_POOL_IBW-1:0] i_fmap,
    output logic                                  o_valid,
    output pool_pkg::act_t [`ST2_POOL_CI-1:0]     o_act,
    output logic                                  o_frame_last
);

    // Tagged input points
    pool_stream_if u_pt ();

    // Pooled words, core to requantizer
    logic                                  pool_valid;
    logic [`ST2_POOL_CI*`ST2_POOL_IBW-1:0] pool_fmap;
    logic                                  pool_last;

    // Cycle 1, position tags
    fmap_position_tracker u_tracker (
        .clk     (clk),
        .reset_n (reset_n),
        .i_valid (i_valid),
        .i_fmap  (i_fmap),
        .o_pt    (u_pt)
    );

    // Cycles 2 and 3, window max and join
    stage2_pooling_core u_core (
        .clk     (clk),
        .reset_n (reset_n),
        .i_pt    (u_pt),
        .o_valid (pool_valid),
        .o_fmap  (pool_fmap),
        .o_last  (pool_last)
    );

    // Cycle 4, 8-bit activations
    pool_requantizer u_requant (
        .clk     (clk),
        .reset_n (reset_n),
        .i_valid (pool_valid),
        .i_fmap  (pool_fmap),
        .i_last  (pool_last),
        .o_valid (o_valid),
        .o_act   (o_act),
        .o_last  (o_frame_last)
    );

endmodule

/* dv/stage2_pool_chk.sv */
module stage2_pool_chk (
    input logic clk,
    input logic reset_n,
    input logic i_out_valid,
    input logic i_frame_last
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////////////////////////
    // Output strobe rules
    //////////////////////////////////////////////////////////////////////

    // Frame end flag only rides on a strobe
    a_last_with_valid: assert property (
        @(posedge clk) disable iff (!reset_n) i_frame_last |-> i_out_valid
    ) else $error("o_frame_last high without o_valid");

    // Only odd columns close a window, so never two in a row
    a_no_back_to_back: assert property (
        @(posedge clk) disable iff (!reset_n) i_out_valid |=> !i_out_valid
    ) else $error("o_valid high on consecutive cycles");

    // Control outputs known out of reset
    a_known: assert property (
        @(posedge clk) disable iff (!reset_n) !$isunknown({i_out_valid, i_frame_last})
    ) else $error("o_valid or o_frame_last unknown");

endmodule

bind stage2_pool_top stage2_pool_chk u_chk (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_out_valid  (o_valid),
    .i_frame_last (o_frame_last)
);

/* dv/stage2_pool_tb.sv */
`include "pool_settings.svh"

module stage2_pool_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import pool_pkg::*;

    localparam int FRAMES  = 4;
    localparam int PTS     = `FMAP_W * `FMAP_H;
    localparam int TOTAL   = FRAMES * PTS;
    localparam int LATENCY = 4;
    // Worst case 4 cycles per point, plus reset and drain
    localparam int TIMEOUT = FRAMES * PTS * 4 + 256;
    localparam int PW      = `ST2_POOL_CI * `ST2_POOL_IBW;
    localparam int AW      = `ST2_POOL_CI * `ST2_POOL_OBW;

    logic                            clk;
    logic                            reset_n;
    logic                            i_valid;
    logic [PW-1:0]                   i_fmap;
    logic                            o_valid;
    act_t [`ST2_POOL_CI-1:0]         o_act;
    logic                            o_frame_last;

    // Model state, one frame of input points
    fmap_word_t frame_mem [`ST2_POOL_CI][`FMAP_H][`FMAP_W];
    int         m_row = 0;
    int         m_col = 0;

    // Expected outputs in order
    logic [AW-1:0] exp_act [$];
    bit            exp_last [$];
    int            exp_cyc [$];

    logic [31:0] lcg_state = 32'd31;
    int          cycle = 0;
    int          sent = 0;

    stage2_pool_top i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_valid      (i_valid),
        .i_fmap       (i_fmap),
        .o_valid      (o_valid),
        .o_act        (o_act),
        .o_frame_last (o_frame_last)
    );

    //////////////////////////////////////////////////////////////////////
    // Random source and reference rules
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Mix of full range, mid-range, large positive and negative words
    function automatic fmap_word_t make_word();
        logic [31:0] r;
        logic [31:0] v;
        fmap_word_t  w;
        r = lcg_step();
        v = lcg_step();
        case (r[31:29])
            3'd0, 3'd7: return fmap_word_t'(v[31:13]);
            3'd1, 3'd2: return fmap_word_t'(v[31:20]);
            3'd3:       return fmap_word_t'(v[31:18]);
            default: begin
                w = fmap_word_t'(v[31:23]);
                return -w - 1'b1;
            end
        endcase
    endfunction

    function automatic logic [PW-1:0] build_point();
        logic [PW-1:0] pt;
        for (int ci = 0; ci < `ST2_POOL_CI; ci++) begin
            pt[ci*`ST2_POOL_IBW +: `ST2_POOL_IBW] = make_word();
        end
        return pt;
    endfunction

    // ReLU, divide by 2^shift, clamp to 8 bits
    function automatic act_t requant_ref(input fmap_word_t w);
        int v;
        v = int'(w);
        if (v < 0) begin
            return 8'd0;
        end
        v = v >> `REQ_SHIFT;
        if (v > 255) begin
            return 8'hff;
        end
        return v[7:0];
    endfunction

    // Store point, queue a result at each window's bottom-right corner
    task automatic record_point(input logic [PW-1:0] pt, input int send_cyc);
        fmap_word_t    win;
        fmap_word_t    cand;
        logic [AW-1:0] acts;
        for (int ci = 0; ci < `ST2_POOL_CI; ci++) begin
            frame_mem[ci][m_row][m_col] = pt[ci*`ST2_POOL_IBW +: `ST2_POOL_IBW];
        end
        if ((m_row % 2 == 1) && (m_col % 2 == 1)) begin
            for (int ci = 0; ci < `ST2_POOL_CI; ci++) begin
                win = frame_mem[ci][m_row][m_col];
                for (int dr = 0; dr < 2; dr++) begin
                    for (int dc = 0; dc < 2; dc++) begin
                        cand = frame_mem[ci][m_row-dr][m_col-dc];
                        if (cand > win) begin
                            win = cand;
                        end
                    end
                end
                acts[ci*`ST2_POOL_OBW +: `ST2_POOL_OBW] = requant_ref(win);
            end
            exp_act.push_back(acts);
            exp_last.push_back((m_row == `FMAP_H - 1) && (m_col == `FMAP_W - 1));
            exp_cyc.push_back(send_cyc);
        end
        // Raster advance, wraps into next frame
        m_col = (m_col == `FMAP_W - 1) ? 0 : m_col + 1;
        if (m_col == 0) begin
            m_row = (m_row == `FMAP_H - 1) ? 0 : m_row + 1;
        end
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Clock, cycle count, watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("Timeout after %0d cycles, outputs still pending", cycle);
            $display("TEST FAILED");
            $fatal(1, "Watchdog expired");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output monitor, sampled on falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : monitor
        logic [AW-1:0] e_act;
        bit            e_last;
        int            e_cyc;
        if (o_valid !== 1'b0) begin
            if (exp_act.size() == 0) begin
                $display("Output strobe at cycle %0d with no pooled point pending", cycle);
                $display("TEST FAILED");
                $fatal(1, "Unexpected output");
            end else begin
                e_act  = exp_act.pop_front();
                e_last = exp_last.pop_front();
                e_cyc  = exp_cyc.pop_front();
                check_equal("o_valid", 32'd1, 32'(o_valid));
                check_equal("o_act", 32'(e_act), 32'(o_act));
                check_equal("o_frame_last", 32'(e_last), 32'(o_frame_last));
                check_equal("o_valid latency", 32'(LATENCY), 32'(cycle - e_cyc));
            end
        end else begin
            check_equal("o_frame_last", 32'd0, 32'(o_frame_last));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [31:0]   r;
        logic [PW-1:0] pt;
        reset_n <= 1'b0;
        i_valid <= 1'b0;
        i_fmap  <= '0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        repeat (3) @(posedge clk);

        // Roughly 3 of 4 cycles carry a point, junk data in gaps
        while (sent < TOTAL) begin
            @(posedge clk);
            r  = lcg_step();
            pt = build_point();
            i_fmap <= pt;
            if (r[31:30] != 2'b00) begin
                i_valid <= 1'b1;
                record_point(pt, cycle + 1);
                sent++;
            end else begin
                i_valid <= 1'b0;
            end
        end
        @(posedge clk);
        i_valid <= 1'b0;

        // Drain, then watch for stray strobes
        while (exp_act.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
logic/pool_pkg.sv
logic/pool_stream_if.sv
logic/fmap_position_tracker.sv
logic/max_pool_2x2.sv
logic/stage2_pooling_core.sv
logic/pool_requantizer.sv
logic/stage2_pool_top.sv
dv/stage2_pool_chk.sv
dv/stage2_pool_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the pooling stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module stage2_pool_tb -o stage2_pool_sim

./obj_dir/stage2_pool_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "Simulation ended without a pass"
    exit 1
fi
exit 0
